// File: rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int XLEN    = 32;
  localparam int NREGS   = 32;
  localparam int SHAMT_W = $clog2(XLEN);

  typedef logic [XLEN-1:0]           word_t;
  typedef logic [31:0]               instr_t;
  typedef logic [$clog2(NREGS)-1:0]  reg_addr_t;
  typedef logic [3:0]                alu_op_t;
  typedef logic [6:0]                opcode_t;
  typedef logic [6:0]                funct7_t;

  // accepted major opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // funct7 values, alt selects sub and sra
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // alu operation codes
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // lui result is the immediate itself
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // decode to execute
  typedef struct packed {
    logic      vld;
    logic      rd_wren;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_imm;
    word_t     imm;
    alu_op_t   alu_op;
  } dec_rec_t;

  // execute to result, also the forwarding source
  typedef struct packed {
    logic      vld;
    logic      rd_wren;
    reg_addr_t rd;
    word_t     data;
  } res_rec_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_wr_en,
  input  rv_pkg::reg_addr_t i_wr_addr,
  input  rv_pkg::word_t     i_wr_data,
  input  rv_pkg::reg_addr_t i_rs1_addr,
  input  rv_pkg::reg_addr_t i_rs2_addr,
  output rv_pkg::word_t     o_rs1_data,
  output rv_pkg::word_t     o_rs2_data
);

  rv_pkg::word_t regs [rv_pkg::NREGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < rv_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // x0 always reads zero
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_instr_vld,
  input  rv_pkg::instr_t   i_instr,
  output rv_pkg::dec_rec_t o_dec,
  output logic             o_illegal
);

  rv_pkg::opcode_t   opcode;
  logic [2:0]        funct3;
  rv_pkg::funct7_t   funct7;
  rv_pkg::reg_addr_t rd;
  rv_pkg::alu_op_t   base_op;
  rv_pkg::alu_op_t   alu_op;
  rv_pkg::word_t     imm;
  logic              use_imm;
  logic              legal;
  rv_pkg::dec_rec_t  dec_d;

  assign opcode = i_instr[6:0];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  // funct3 gives the same operation for OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  base_op = rv_pkg::ALU_ADD;
      3'b001:  base_op = rv_pkg::ALU_SLL;
      3'b010:  base_op = rv_pkg::ALU_SLT;
      3'b011:  base_op = rv_pkg::ALU_SLTU;
      3'b100:  base_op = rv_pkg::ALU_XOR;
      3'b101:  base_op = rv_pkg::ALU_SRL;
      3'b110:  base_op = rv_pkg::ALU_OR;
      default: base_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    legal   = 1'b0;
    use_imm = 1'b0;
    alu_op  = base_op;
    // i-type immediate, sign extended
    imm     = {{20{i_instr[31]}}, i_instr[31:20]};
    case (opcode)
      rv_pkg::OPC_OP: begin
        if (funct7 == rv_pkg::F7_BASE) begin
          legal = 1'b1;
        end else if (funct7 == rv_pkg::F7_ALT) begin
          // only sub and sra have an alternate form
          if (funct3 == 3'b000) begin
            legal  = 1'b1;
            alu_op = rv_pkg::ALU_SUB;
          end else if (funct3 == 3'b101) begin
            legal  = 1'b1;
            alu_op = rv_pkg::ALU_SRA;
          end
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        if (funct3 == 3'b001) begin
          legal = (funct7 == rv_pkg::F7_BASE);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
          if (funct7 == rv_pkg::F7_ALT) begin
            alu_op = rv_pkg::ALU_SRA;
          end
        end else begin
          legal = 1'b1;
        end
      end
      rv_pkg::OPC_LUI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        alu_op  = rv_pkg::ALU_PASS_B;
        imm     = {i_instr[31:12], 12'b0};
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_d.vld     = i_instr_vld && legal;
    // x0 writes are dropped here once
    dec_d.rd_wren = legal && (rd != '0);
    dec_d.rd      = rd;
    dec_d.rs1     = i_instr[19:15];
    dec_d.rs2     = i_instr[24:20];
    dec_d.use_imm = use_imm;
    dec_d.imm     = imm;
    dec_d.alu_op  = alu_op;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec     <= '0;
      o_illegal <= 1'b0;
    end else begin
      o_dec     <= dec_d;
      o_illegal <= i_instr_vld && !legal;
    end
  end

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  rv_pkg::dec_rec_t  i_dec,
  input  rv_pkg::res_rec_t  i_fwd,
  output rv_pkg::reg_addr_t o_rs1_addr,
  output rv_pkg::reg_addr_t o_rs2_addr,
  input  rv_pkg::word_t     i_rs1_data,
  input  rv_pkg::word_t     i_rs2_data,
  output rv_pkg::res_rec_t  o_res
);

  logic                      fwd_a;
  logic                      fwd_b;
  rv_pkg::word_t             rs1_val;
  rv_pkg::word_t             rs2_val;
  rv_pkg::word_t             operand_a;
  rv_pkg::word_t             operand_b;
  logic [rv_pkg::SHAMT_W-1:0] shamt;
  rv_pkg::word_t             alu_data;
  rv_pkg::res_rec_t          res_d;

  assign o_rs1_addr = i_dec.rs1;
  assign o_rs2_addr = i_dec.rs2;

  // previous instruction still sits in the result record,
  // rd_wren is already low there for x0
  assign fwd_a = i_fwd.vld && i_fwd.rd_wren && (i_fwd.rd == i_dec.rs1);
  assign fwd_b = i_fwd.vld && i_fwd.rd_wren && (i_fwd.rd == i_dec.rs2);

  assign rs1_val = fwd_a ? i_fwd.data : i_rs1_data;
  assign rs2_val = fwd_b ? i_fwd.data : i_rs2_data;

  assign operand_a = rs1_val;
  assign operand_b = i_dec.use_imm ? i_dec.imm : rs2_val;
  assign shamt     = operand_b[rv_pkg::SHAMT_W-1:0];

  always_comb begin
    case (i_dec.alu_op)
      rv_pkg::ALU_ADD:  alu_data = operand_a + operand_b;
      rv_pkg::ALU_SUB:  alu_data = operand_a - operand_b;
      rv_pkg::ALU_SLL:  alu_data = operand_a << shamt;
      rv_pkg::ALU_SLT: begin
        alu_data = {31'b0, $signed(operand_a) < $signed(operand_b)};
      end
      rv_pkg::ALU_SLTU: begin
        alu_data = {31'b0, operand_a < operand_b};
      end
      rv_pkg::ALU_XOR:  alu_data = operand_a ^ operand_b;
      rv_pkg::ALU_SRL:  alu_data = operand_a >> shamt;
      rv_pkg::ALU_SRA:  alu_data = $signed(operand_a) >>> shamt;
      rv_pkg::ALU_OR:   alu_data = operand_a | operand_b;
      rv_pkg::ALU_AND:  alu_data = operand_a & operand_b;
      default:          alu_data = operand_b;
    endcase
  end

  always_comb begin
    res_d.vld     = i_dec.vld;
    res_d.rd_wren = i_dec.rd_wren;
    res_d.rd      = i_dec.rd;
    res_d.data    = alu_data;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_res <= '0;
    end else begin
      o_res <= res_d;
    end
  end

endmodule

// File: rv_result.sv
`timescale 1ns/1ps

module rv_result (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  rv_pkg::res_rec_t  i_res,
  output logic              o_wr_en,
  output rv_pkg::reg_addr_t o_wr_addr,
  output rv_pkg::word_t     o_wr_data,
  output logic              o_wb_vld,
  output rv_pkg::reg_addr_t o_wb_rd,
  output rv_pkg::word_t     o_wb_data,
  output rv_pkg::word_t     o_retired
);

  logic wr_en;

  // rd_wren is low for x0 and illegal encodings
  assign wr_en = i_res.vld && i_res.rd_wren;

  assign o_wr_en   = wr_en;
  assign o_wr_addr = i_res.rd;
  assign o_wr_data = i_res.data;

  // write-back ports mirror the register write
  assign o_wb_vld  = wr_en;
  assign o_wb_rd   = i_res.rd;
  assign o_wb_data = i_res.data;

  // retired register writes, lands with the regfile write
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_retired <= '0;
    end else if (wr_en) begin
      o_retired <= o_retired + 1'b1;
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_instr_vld,
  input  rv_pkg::instr_t    i_instr,
  output logic              o_wb_vld,
  output rv_pkg::reg_addr_t o_wb_rd,
  output rv_pkg::word_t     o_wb_data,
  output logic              o_illegal,
  output rv_pkg::word_t     o_retired
);

  rv_pkg::dec_rec_t  dec_rec;
  rv_pkg::res_rec_t  res_rec;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  logic              wr_en;
  rv_pkg::reg_addr_t wr_addr;
  rv_pkg::word_t     wr_data;

  rv_decode rv_decode_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .i_instr     (i_instr),
    .o_dec       (dec_rec),
    .o_illegal   (o_illegal)
  );

  rv_regfile rv_regfile_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // result record doubles as the forwarding source
  rv_execute rv_execute_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_dec      (dec_rec),
    .i_fwd      (res_rec),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_res      (res_rec)
  );

  rv_result rv_result_inst (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_res     (res_rec),
    .o_wr_en   (wr_en),
    .o_wr_addr (wr_addr),
    .o_wr_data (wr_data),
    .o_wb_vld  (o_wb_vld),
    .o_wb_rd   (o_wb_rd),
    .o_wb_data (o_wb_data),
    .o_retired (o_retired)
  );

endmodule

// File: rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_instr_vld,
  input logic              o_wb_vld,
  input rv_pkg::reg_addr_t o_wb_rd,
  input logic              o_illegal,
  input rv_pkg::word_t     o_retired
);

  // a write-back strobe never names x0
  wb_rd_nonzero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) o_wb_vld |-> (o_wb_rd != '0)
  ) else $error("write-back strobe names register x0");

  // counter lands one edge after the strobe
  retired_step: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_wb_vld |=> (o_retired == $past(o_retired) + 32'd1)
  ) else $error("retired count did not rise by one after a write-back");

  retired_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !o_wb_vld |=> $stable(o_retired)
  ) else $error("retired count changed without a write-back");

  // an idle slot cannot raise the illegal flag
  illegal_needs_vld: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !i_instr_vld |=> !o_illegal
  ) else $error("illegal flag raised after a slot with no instruction");

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 2;
  localparam int NUM_INSTR  = 2000;
  // ~80% valid slots, so the stream plus drain fits in half again its length
  localparam int MAX_CYCLES = NUM_INSTR * 3 / 2 + RST_CYCLES;

  // base opcodes from the instruction set
  localparam logic [6:0] OP_R   = 7'b0110011;
  localparam logic [6:0] OP_I   = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;

  typedef struct packed {
    int                slot;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;
  } exp_wr_t;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_instr_vld;
  rv_pkg::instr_t    i_instr;
  logic              o_wb_vld;
  rv_pkg::reg_addr_t o_wb_rd;
  rv_pkg::word_t     o_wb_data;
  logic              o_illegal;
  rv_pkg::word_t     o_retired;

  integer        seed;
  int            slot;
  int            cycle_count = 0;
  int            err_count = 0;
  int            check_count = 0;
  int            issued = 0;
  int            exp_writes = 0;
  int            exp_illegal = 0;
  rv_pkg::word_t model_regs [32];
  exp_wr_t       wr_q [$];
  int            ill_q [$];

  rv_core rv_core_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .i_instr     (i_instr),
    .o_wb_vld    (o_wb_vld),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_illegal   (o_illegal),
    .o_retired   (o_retired)
  );

  bind rv_core rv_core_assertions rv_core_assertions_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .o_wb_vld    (o_wb_vld),
    .o_wb_rd     (o_wb_rd),
    .o_illegal   (o_illegal),
    .o_retired   (o_retired)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("checks: %0d, errors: %0d", check_count, err_count);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic bit is_legal(input logic [31:0] ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    if (opc == OP_LUI) return 1'b1;
    if (opc == OP_R) return (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    if (opc == OP_I) begin
      if (f3 == 3'd1) return f7 == 7'h00;
      if (f3 == 3'd5) return (f7 == 7'h00) || (f7 == 7'h20);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // reference result of one legal instruction
  function automatic logic [31:0] model_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] r2);
    logic [31:0] b;
    logic [4:0]  sh;
    if (ins[6:0] == OP_LUI) return {ins[31:12], 12'h000};
    b  = (ins[6:0] == OP_I) ? {{20{ins[31]}}, ins[31:20]} : r2;
    sh = b[4:0];
    case (ins[14:12])
      3'd0: return (ins[6:0] == OP_R && ins[30]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (ins[30]) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic gen_instr(output logic [31:0] ins);
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [31:0] bits;
    int          pick;
    kind = {$random(seed)} % 12;
    // small register range keeps dependences frequent
    rd   = {$random(seed)} % 8;
    rs1  = {$random(seed)} % 8;
    rs2  = {$random(seed)} % 8;
    f3   = $random(seed);
    imm  = $random(seed);
    bits = $random(seed);
    if (kind < 5) begin
      ins = {((f3 == 3'd0 || f3 == 3'd5) && bits[31]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP_R};
    end else if (kind < 9) begin
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = bits[31] ? 7'h20 : 7'h00;
      ins = {imm, rs1, f3, rd, OP_I};
    end else if (kind < 11) begin
      ins = {bits[19:0], rd, OP_LUI};
    end else begin
      pick = {$random(seed)} % 4;
      case (pick)
        0: begin
          ins = bits;
          if (ins[6:0] == OP_R || ins[6:0] == OP_I || ins[6:0] == OP_LUI) ins[6:0] = 7'h7f;
        end
        1: ins = {7'h01, rs2, rs1, f3, rd, OP_R};
        2: begin
          // alternate funct7 on an operation that has none
          pick = {$random(seed)} % 5;
          f3   = (pick < 3) ? pick + 2 : pick + 3;
          ins  = {7'h20, rs2, rs1, f3, rd, OP_R};
        end
        default: ins = bits[31] ? {7'h20, rs2, rs1, 3'd1, rd, OP_I}
                                : {7'h01, rs2, rs1, 3'd5, rd, OP_I};
      endcase
    end
  endtask

  task automatic issue_instr(input logic [31:0] ins);
    exp_wr_t wr;
    if (!is_legal(ins)) begin
      ill_q.push_back(slot + 1);
      exp_illegal++;
    end else if (ins[11:7] != 5'd0) begin
      wr.slot = slot + 2;
      wr.rd   = ins[11:7];
      wr.data = model_result(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
      model_regs[wr.rd] = wr.data;
      wr_q.push_back(wr);
      exp_writes++;
    end
  endtask

  task automatic sample_outputs();
    exp_wr_t wr;
    logic    exp_wb;
    logic    exp_ill;
    exp_wb  = (wr_q.size() != 0) && (wr_q[0].slot == slot);
    exp_ill = (ill_q.size() != 0) && (ill_q[0] == slot);
    check_count += 2;
    assert (o_wb_vld == exp_wb) else begin
      $display("mismatch at %0t: o_wb_vld expected %0b got %0b", $time, exp_wb, o_wb_vld);
      err_count++;
    end
    assert (o_illegal == exp_ill) else begin
      $display("mismatch at %0t: o_illegal expected %0b got %0b", $time, exp_ill, o_illegal);
      err_count++;
    end
    if (exp_ill) void'(ill_q.pop_front());
    if (exp_wb) begin
      wr = wr_q.pop_front();
      if (o_wb_vld) begin
        check_count += 2;
        assert (o_wb_rd == wr.rd) else begin
          $display("mismatch at %0t: o_wb_rd expected %0d got %0d", $time, wr.rd, o_wb_rd);
          err_count++;
        end
        assert (o_wb_data == wr.data) else begin
          $display("mismatch at %0t: o_wb_data expected %h got %h", $time, wr.data, o_wb_data);
          err_count++;
        end
      end
    end
  endtask

  task automatic next_slot(input bit active);
    logic [31:0] ins;
    @(negedge i_clk);
    slot++;
    sample_outputs();
    if (active && ({$random(seed)} % 10) < 8) begin
      gen_instr(ins);
      i_instr     = ins;
      i_instr_vld = 1'b1;
      issue_instr(ins);
      issued++;
    end else begin
      i_instr_vld = 1'b0;
      i_instr     = $random(seed);
    end
  endtask

  initial begin
    seed        = 32'h6e68;
    i_rst_n     = 1'b0;
    i_instr_vld = 1'b0;
    i_instr     = '0;
    slot        = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (RST_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    check_count += 3;
    assert (o_wb_vld == 1'b0) else begin
      $display("mismatch at %0t: o_wb_vld in reset expected 0 got %0b", $time, o_wb_vld);
      err_count++;
    end
    assert (o_illegal == 1'b0) else begin
      $display("mismatch at %0t: o_illegal in reset expected 0 got %0b", $time, o_illegal);
      err_count++;
    end
    assert (o_retired == '0) else begin
      $display("mismatch at %0t: o_retired in reset expected 0 got %0d", $time, o_retired);
      err_count++;
    end
    i_rst_n = 1'b1;
    while (issued < NUM_INSTR) begin
      next_slot(1'b1);
    end
    // drain the pipeline, then watch for stray strobes
    while (wr_q.size() != 0 || ill_q.size() != 0) begin
      next_slot(1'b0);
    end
    repeat (4) next_slot(1'b0);
    check_count++;
    assert (o_retired == exp_writes) else begin
      $display("mismatch at %0t: o_retired expected %0d got %0d", $time, exp_writes, o_retired);
      err_count++;
    end
    $display("checks: %0d, errors: %0d, writes: %0d, illegal: %0d",
             check_count, err_count, exp_writes, exp_illegal);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb.f
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_core_assertions.sv
      - tb_rv_core.sv
